/* Bender.yml */
package:
  name: cmac

sources:
  - cmac_pkg.sv
  - fixed_mult.sv
  - cmac_decode.sv
  - cmac_execute.sv
  - cmac_result.sv
  - cmac_top.sv
  - target: test
    files:
      - cmac_properties.sv
      - tb_cmac.sv

/* cmac_decode.sv */
`timescale 1ns/1ns

module cmac_decode (
    input  logic                clk,
    input  logic                reset,
    input  logic                in_valid,
    output logic                in_ready,
    input  cmac_pkg::op_t       op,
    input  cmac_pkg::word_t     ar,
    input  cmac_pkg::word_t     ac,
    input  cmac_pkg::word_t     br,
    input  cmac_pkg::word_t     bc,
    output logic                dec_valid,
    input  logic                dec_ready,
    output cmac_pkg::word_t     dec_ar,
    output cmac_pkg::word_t     dec_ac,
    output cmac_pkg::word_t     dec_br,
    output cmac_pkg::word_t     dec_bc,
    output cmac_pkg::acc_mode_t dec_mode
);

    import cmac_pkg::*;

    word_t     nxt_ar;
    word_t     nxt_ac;
    word_t     nxt_bc;
    acc_mode_t nxt_mode;

    // the register can take a new command when empty or when drained this cycle
    assign in_ready = !dec_valid || dec_ready;

    always_comb begin
        nxt_ar   = ar;
        nxt_ac   = ac;
        nxt_bc   = bc;
        nxt_mode = acc_keep;
        case (op)
            op_conj:  nxt_bc = -bc; // a * conj(b) is a times (br - j bc)
            op_mac:   nxt_mode = acc_add;
            op_clear: begin
                // a zero operand gives a zero product, which is then loaded
                nxt_ar   = '0;
                nxt_ac   = '0;
                nxt_mode = acc_load;
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            dec_valid <= 1'b0;
        end else if (in_ready) begin
            dec_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            dec_ar   <= nxt_ar;
            dec_ac   <= nxt_ac;
            dec_br   <= br;
            dec_bc   <= nxt_bc;
            dec_mode <= nxt_mode;
        end
    end

endmodule

/* cmac_execute.sv */
`timescale 1ns/1ns

module cmac_execute (
    input  logic                clk,
    input  logic                reset,
    input  logic                dec_valid,
    output logic                dec_ready,
    input  cmac_pkg::word_t     dec_ar,
    input  cmac_pkg::word_t     dec_ac,
    input  cmac_pkg::word_t     dec_br,
    input  cmac_pkg::word_t     dec_bc,
    input  cmac_pkg::acc_mode_t dec_mode,
    output logic                ex_valid,
    input  logic                ex_ready,
    output cmac_pkg::word_t     ex_re,
    output cmac_pkg::word_t     ex_im,
    output cmac_pkg::acc_mode_t ex_mode
);

    import cmac_pkg::*;

    exec_state_t state;
    exec_state_t next_state;

    word_t c_ar;
    word_t c_ac;
    word_t c_br;
    word_t c_bc;

    word_t p1;
    word_t p2;
    word_t p3;

    word_t mul_a;
    word_t mul_b;
    word_t mul_c;

    assign dec_ready = (state == st_idle);
    assign ex_valid  = (state == st_done);

    // a single multiplier is shared by the three products
    always_comb begin
        next_state = state;
        mul_a      = '0;
        mul_b      = '0;
        case (state)
            st_idle: begin
                if (dec_valid)
                    next_state = st_mul1;
            end
            st_mul1: begin
                mul_a      = c_ar;
                mul_b      = c_br;
                next_state = st_mul2;
            end
            st_mul2: begin
                mul_a      = c_ac;
                mul_b      = c_bc;
                next_state = st_mul3;
            end
            st_mul3: begin
                mul_a      = c_ar + c_ac; // sums wrap to one word before the multiply
                mul_b      = c_br + c_bc;
                next_state = st_done;
            end
            st_done: begin
                if (ex_ready)
                    next_state = st_idle;
            end
            default: next_state = st_idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset)
            state <= st_idle;
        else
            state <= next_state;
    end

    always_ff @(posedge clk) begin
        if (state == st_idle && dec_valid) begin
            c_ar    <= dec_ar;
            c_ac    <= dec_ac;
            c_br    <= dec_br;
            c_bc    <= dec_bc;
            ex_mode <= dec_mode; // the mode follows its operands down the pipe
        end
        if (state == st_mul1)
            p1 <= mul_c;
        if (state == st_mul2)
            p2 <= mul_c;
        if (state == st_mul3)
            p3 <= mul_c;
    end

    fixed_mult mult0 (
        .a(mul_a),
        .b(mul_b),
        .c(mul_c)
    );

    assign ex_re = p1 - p2;
    assign ex_im = p3 - p1 - p2; // ar*bc + ac*br without a fourth multiply

endmodule

/* cmac_pkg.sv */
package cmac_pkg;

    localparam int word_bits = 32;
    localparam int frac_bits = 16;

    // one real or imaginary value in Q16.16
    typedef logic signed [word_bits-1:0] word_t;
    typedef logic signed [2*word_bits-1:0] prod_t; // full product before the shift

    typedef logic [1:0] op_t;

    localparam op_t op_mul   = 2'd0;
    localparam op_t op_conj  = 2'd1;
    localparam op_t op_mac   = 2'd2;
    localparam op_t op_clear = 2'd3;

    // tells the result stage what to do with the accumulator
    typedef logic [1:0] acc_mode_t;

    localparam acc_mode_t acc_keep = 2'd0; // output the product, accumulator untouched
    localparam acc_mode_t acc_add  = 2'd1;
    localparam acc_mode_t acc_load = 2'd2;

    typedef enum logic [2:0] {
        st_idle,
        st_mul1,
        st_mul2,
        st_mul3,
        st_done
    } exec_state_t;

endpackage

/* cmac_properties.sv */
`timescale 1ns/1ns

module cmac_properties (
    input logic            clk,
    input logic            reset,
    input logic            in_valid,
    input logic            in_ready,
    input cmac_pkg::op_t   op,
    input cmac_pkg::word_t ar,
    input cmac_pkg::word_t ac,
    input cmac_pkg::word_t br,
    input cmac_pkg::word_t bc,
    input logic            out_valid,
    input logic            out_ready,
    input cmac_pkg::word_t out_re,
    input cmac_pkg::word_t out_im
);

    // a waiting command stays offered and unchanged until it is taken
    assert property (@(posedge clk) disable iff (reset)
        in_valid && !in_ready |=> in_valid && $stable({op, ar, ac, br, bc}))
        else $error("input command dropped or changed before it was accepted");

    assert property (@(posedge clk) disable iff (reset)
        out_valid && !out_ready |=> out_valid && $stable({out_re, out_im}))
        else $error("output result dropped or changed before it was taken");

    assert property (@(posedge clk) reset |=> !out_valid) // one reset edge clears the output
        else $error("out_valid high during reset");

    assert property (@(posedge clk) $fell(reset) |-> in_ready)
        else $error("in_ready low on the first cycle after reset");

endmodule

bind cmac_top cmac_properties props0 (.*);

/* cmac_result.sv */
`timescale 1ns/1ns

module cmac_result (
    input  logic                clk,
    input  logic                reset,
    input  logic                ex_valid,
    output logic                ex_ready,
    input  cmac_pkg::word_t     ex_re,
    input  cmac_pkg::word_t     ex_im,
    input  cmac_pkg::acc_mode_t ex_mode,
    output logic                out_valid,
    input  logic                out_ready,
    output cmac_pkg::word_t     out_re,
    output cmac_pkg::word_t     out_im
);

    import cmac_pkg::*;

    word_t acc_re;
    word_t acc_im;
    word_t nxt_acc_re;
    word_t nxt_acc_im;
    word_t res_re;
    word_t res_im;

    logic take;

    assign ex_ready = !out_valid || out_ready;
    assign take     = ex_valid && ex_ready;

    always_comb begin
        nxt_acc_re = acc_re;
        nxt_acc_im = acc_im;
        res_re     = ex_re; // keep mode passes the product straight out
        res_im     = ex_im;
        case (ex_mode)
            acc_add: begin
                nxt_acc_re = acc_re + ex_re;
                nxt_acc_im = acc_im + ex_im;
                res_re     = nxt_acc_re;
                res_im     = nxt_acc_im;
            end
            acc_load: begin
                nxt_acc_re = ex_re;
                nxt_acc_im = ex_im;
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            acc_re    <= '0;
            acc_im    <= '0;
            out_valid <= 1'b0;
        end else begin
            if (take) begin
                acc_re <= nxt_acc_re;
                acc_im <= nxt_acc_im;
            end
            if (ex_ready)
                out_valid <= ex_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            out_re <= res_re;
            out_im <= res_im;
        end
    end

endmodule

/* cmac_top.sv */
`timescale 1ns/1ns

module cmac_top (
    input  logic            clk,
    input  logic            reset,
    input  logic            in_valid,
    output logic            in_ready,
    input  cmac_pkg::op_t   op,
    input  cmac_pkg::word_t ar,
    input  cmac_pkg::word_t ac,
    input  cmac_pkg::word_t br,
    input  cmac_pkg::word_t bc,
    output logic            out_valid,
    input  logic            out_ready,
    output cmac_pkg::word_t out_re,
    output cmac_pkg::word_t out_im
);

    import cmac_pkg::*;

    logic      dec_valid;
    logic      dec_ready;
    word_t     dec_ar;
    word_t     dec_ac;
    word_t     dec_br;
    word_t     dec_bc;
    acc_mode_t dec_mode;

    logic      ex_valid;
    logic      ex_ready;
    word_t     ex_re;
    word_t     ex_im;
    acc_mode_t ex_mode;

    cmac_decode decode0 (
        .clk(clk), .reset(reset),
        .in_valid(in_valid), .in_ready(in_ready),
        .op(op), .ar(ar), .ac(ac), .br(br), .bc(bc),
        .dec_valid(dec_valid), .dec_ready(dec_ready),
        .dec_ar(dec_ar), .dec_ac(dec_ac), .dec_br(dec_br), .dec_bc(dec_bc),
        .dec_mode(dec_mode)
    );

    cmac_execute execute0 (
        .clk(clk), .reset(reset),
        .dec_valid(dec_valid), .dec_ready(dec_ready),
        .dec_ar(dec_ar), .dec_ac(dec_ac), .dec_br(dec_br), .dec_bc(dec_bc),
        .dec_mode(dec_mode),
        .ex_valid(ex_valid), .ex_ready(ex_ready),
        .ex_re(ex_re), .ex_im(ex_im), .ex_mode(ex_mode)
    );

    cmac_result result0 (
        .clk(clk), .reset(reset),
        .ex_valid(ex_valid), .ex_ready(ex_ready),
        .ex_re(ex_re), .ex_im(ex_im), .ex_mode(ex_mode),
        .out_valid(out_valid), .out_ready(out_ready),
        .out_re(out_re), .out_im(out_im)
    );

endmodule

/* fixed_mult.sv */
`timescale 1ns/1ns

module fixed_mult (
    input  cmac_pkg::word_t a,
    input  cmac_pkg::word_t b,
    output cmac_pkg::word_t c
);

    import cmac_pkg::*;

    prod_t full;
    prod_t shifted;

    // both operands are sign extended before the multiply
    assign full = prod_t'(a) * prod_t'(b);

    // drop the extra fraction bits, no rounding
    assign shifted = full >>> frac_bits;

    assign c = shifted[word_bits-1:0]; // upper bits are lost, the result wraps

endmodule

/* src.f */
cmac_pkg.sv
fixed_mult.sv
cmac_decode.sv
cmac_execute.sv
cmac_result.sv
cmac_top.sv
cmac_properties.sv
tb_cmac.sv

/* tb_cmac.sv */
`timescale 1ns/1ns

module tb_cmac;

    import cmac_pkg::*;

    localparam int wait_limit = 200;

    logic  clk;
    logic  reset;
    logic  in_valid;
    logic  in_ready;
    op_t   op;
    word_t ar;
    word_t ac;
    word_t br;
    word_t bc;
    logic  out_valid;
    logic  out_ready;
    word_t out_re;
    word_t out_im;

    integer seed = 32'hcf6d_24e0;
    integer ready_seed = 32'hcf6d_24e0 ^ 32'h0000_ffff; // keeps ready apart from operands
    logic   random_ready = 1'b0;
    int     errors = 0;
    int     command_count = 0;
    int     result_count = 0;
    word_t  acc_re = '0; // model of the DUT accumulator
    word_t  acc_im = '0;

    logic [129:0] cmd_queue[$]; // each entry is op, ar, ac, br, bc

    cmac_top dut0 (
        .clk(clk), .reset(reset),
        .in_valid(in_valid), .in_ready(in_ready),
        .op(op), .ar(ar), .ac(ac), .br(br), .bc(bc),
        .out_valid(out_valid), .out_ready(out_ready),
        .out_re(out_re), .out_im(out_im)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;

    // Q16.16 product, shifted right by the fraction bits and cut to one word
    function automatic word_t fixed_product(word_t a, word_t b);
        longint full;
        full = longint'(a) * longint'(b);
        return word_t'(full >>> frac_bits);
    endfunction

    function automatic logic [63:0] reference_result(logic [129:0] cmd, word_t m_re,
                                                     word_t m_im);
        op_t   c_op;
        word_t x_ar;
        word_t x_ac;
        word_t x_br;
        word_t x_bc;
        word_t p1;
        word_t p2;
        word_t p3;
        word_t re;
        word_t im;
        {c_op, x_ar, x_ac, x_br, x_bc} = cmd;
        if (c_op == op_conj)
            x_bc = -x_bc;
        if (c_op == op_clear) begin
            x_ar = '0;
            x_ac = '0;
        end
        p1 = fixed_product(x_ar, x_br);
        p2 = fixed_product(x_ac, x_bc);
        p3 = fixed_product(word_t'(x_ar + x_ac), word_t'(x_br + x_bc)); // both sums wrap first
        re = p1 - p2;
        im = p3 - p1 - p2;
        if (c_op == op_mac) begin
            re = m_re + re;
            im = m_im + im;
        end
        return {re, im};
    endfunction

    task automatic check_word(input string name, input word_t expected, input word_t actual);
        if (actual !== expected) begin
            $display("[ERROR] %0t %s expected %h actual %h", $time, name, expected, actual);
            errors++;
        end
    endtask

    task automatic finish_run();
        $display("commands %0d, results %0d, errors %0d", command_count, result_count, errors);
        if (errors == 0)
            $display("All tests passed");
        else
            $display("Some tests failed");
        $finish;
    endtask

    task automatic give_up(input string why);
        $display("timeout: %s", why);
        errors++;
        finish_run();
    endtask

    task automatic send_command(input op_t c_op, input word_t c_ar, input word_t c_ac,
                                input word_t c_br, input word_t c_bc);
        int waited;
        waited   = 0;
        op       <= c_op;
        ar       <= c_ar;
        ac       <= c_ac;
        br       <= c_br;
        bc       <= c_bc;
        in_valid <= 1'b1;
        @(posedge clk);
        while (!in_ready) begin
            waited++;
            if (waited > wait_limit)
                give_up("the DUT did not accept a command");
            @(posedge clk);
        end
        in_valid <= 1'b0;
    endtask

    task automatic send_random(input op_t c_op);
        send_command(c_op, $random(seed), $random(seed), $random(seed), $random(seed));
    endtask

    task automatic wait_for_drain();
        int waited;
        waited = 0;
        do begin
            @(posedge clk);
            waited++;
            if (waited > wait_limit)
                give_up("a result was missing after the last command");
        end while (result_count != command_count);
    endtask

    task automatic end_test(input string name, input int errors_before);
        wait_for_drain();
        if (errors == errors_before)
            $display("test %s: ok", name);
        else
            $display("test %s: %0d errors", name, errors - errors_before);
    endtask

    always @(posedge clk) begin
        if (random_ready)
            out_ready <= ($random(ready_seed) & 3) != 0; // ready about three cycles in four
        else
            out_ready <= 1'b1;
    end

    always @(posedge clk) begin
        if (!reset && in_valid && in_ready) begin
            cmd_queue.push_back({op, ar, ac, br, bc});
            command_count++;
        end
    end

    always @(posedge clk) begin
        logic [129:0] cmd;
        logic [63:0]  expected;
        if (!reset && out_valid && out_ready) begin
            if (cmd_queue.size() == 0) begin
                $display("%0t: a result came out with no command waiting for it", $time);
                errors++;
            end else begin
                cmd      = cmd_queue.pop_front();
                expected = reference_result(cmd, acc_re, acc_im);
                check_word("out_re", expected[63:32], out_re);
                check_word("out_im", expected[31:0], out_im);
                if (cmd[129:128] == op_mac || cmd[129:128] == op_clear) begin
                    acc_re = expected[63:32];
                    acc_im = expected[31:0];
                end
            end
            result_count++;
        end
    end

    initial begin
        int mark;
        reset     = 1'b1;
        in_valid  = 1'b0;
        op        = op_mul;
        ar        = '0;
        ac        = '0;
        br        = '0;
        bc        = '0;
        out_ready = 1'b1;
        repeat (8) @(posedge clk);
        reset <= 1'b0;
        @(posedge clk);

        mark = errors;
        if (in_ready !== 1'b1 || out_valid !== 1'b0) begin
            $display("after reset in_ready was not high or out_valid was not low");
            errors++;
        end
        send_command(op_mac, 32'h0002_0000, 32'h0001_0000, 32'h0000_8000, 32'hffff_0000);
        end_test("reset", mark);

        mark = errors;
        send_command(op_mul, 32'h0001_8000, 32'h0000_0000, 32'h0002_0000, 32'h0000_0000);
        send_command(op_mul, 32'hfffe_0000, 32'h0003_4000, 32'h0001_0000, 32'hffff_8000);
        send_command(op_mul, 32'h7fff_ffff, 32'h7fff_ffff, 32'h7fff_ffff, 32'h0001_0000);
        send_command(op_mul, 32'h8000_0000, 32'h8000_0000, 32'h8000_0000, 32'h8000_0000);
        repeat (20) send_random(op_mul);
        end_test("multiply", mark);

        mark = errors;
        send_command(op_conj, 32'h0001_0000, 32'h0002_0000, 32'h0003_0000, 32'h0004_0000);
        send_command(op_conj, 32'h8000_0000, 32'hffff_0001, 32'h1234_5678, 32'h8000_0000);
        repeat (10) send_random(op_conj);
        send_random(op_mac); // builds on the accumulator left by the first test
        send_random(op_mul);
        send_random(op_mac);
        end_test("conjugate", mark);

        mark = errors;
        send_random(op_clear);
        repeat (5) send_random(op_mac);
        send_random(op_clear);
        repeat (4) send_random(op_mac);
        end_test("accumulate and clear", mark);

        mark = errors;
        random_ready <= 1'b1;
        for (int burst = 0; burst < 8; burst++) begin
            repeat (($random(seed) & 3) + 1) send_random(op_t'($random(seed)));
            repeat ($random(seed) & 7) @(posedge clk);
        end
        end_test("back-pressure", mark);

        mark = errors;
        repeat (200) send_random(op_t'($random(seed)));
        wait_for_drain();
        repeat (20) @(posedge clk); // a duplicated result would show up in this quiet window
        if (cmd_queue.size() != 0 || result_count != command_count) begin
            $display("%0d results for %0d commands, %0d left in the model queue",
                     result_count, command_count, cmd_queue.size());
            errors++;
        end
        end_test("random mix", mark);

        finish_run();
    end

endmodule
